// File: src/simd_fp_pkg.sv
// ------------------------------
// Formats, opcodes, flags and width helpers of the SIMD noncomp slice
// Every RTL file takes what it needs by wildcard import
// ------------------------------
package simd_fp_pkg;

  // ------------------------------
  // Sizes
  // ------------------------------
  localparam int unsigned TAG_BITS     = 8;
  localparam int unsigned MIN_FP_WIDTH = 16; // Narrowest format, sets the lane count

  // ------------------------------
  // Formats and operations
  // ------------------------------
  typedef enum logic {
    FP32 = 1'b0,
    FP16 = 1'b1
  } fp_fmt_e;

  // Sign injection and min/max group
  typedef enum logic [2:0] {
    SGNJ  = 3'd0,
    SGNJN = 3'd1,
    SGNJX = 3'd2,
    MIN   = 3'd3,
    MAX   = 3'd4
  } noncomp_op_e;

  // IEEE exception flags, only nv is raised by this group
  typedef struct packed {
    logic nv; // Invalid operation
    logic dz; // Divide by zero
    logic of; // Overflow
    logic uf; // Underflow
    logic nx; // Inexact
  } status_t;

  // Quiet NaN returned when both min/max inputs are NaN
  localparam logic [31:0] CANON_NAN_FP32 = 32'h7FC0_0000;
  localparam logic [15:0] CANON_NAN_FP16 = 16'h7E00;

  // ------------------------------
  // Width helpers
  // ------------------------------
  // Slot width of one lane for a format
  function automatic int unsigned fp_width(fp_fmt_e fmt);
    return (fmt == FP16) ? 16 : 32;
  endfunction

  // Lanes needed to hold the narrowest format across the datapath
  function automatic int unsigned num_lanes(int unsigned width);
    return width / MIN_FP_WIDTH;
  endfunction

endpackage

// File: src/lane_if.sv
// ------------------------------
// Stage-to-stage buses of the slice pipeline
// Operand bus feeds the lane stage, result bus feeds the packer
// ------------------------------
interface lane_operand_if import simd_fp_pkg::*; #(
  parameter int unsigned Width = 64
) ();
  localparam int unsigned NumLanes = num_lanes(Width);

  logic                valid;
  logic                ready;
  noncomp_op_e         op;
  fp_fmt_e             fmt;
  logic [NumLanes-1:0] lane_active; // Lanes that carry real work
  logic [NumLanes-1:0] mask;        // High lets the lane's flags through
  logic [TAG_BITS-1:0] tag;
  logic [Width-1:0]    opa;
  logic [Width-1:0]    opb;

  modport producer (output valid, op, fmt, lane_active, mask, tag, opa, opb, input ready);
  modport consumer (input valid, op, fmt, lane_active, mask, tag, opa, opb, output ready);
endinterface

interface lane_result_if import simd_fp_pkg::*; #(
  parameter int unsigned Width = 64
) ();
  localparam int unsigned NumLanes = num_lanes(Width);

  logic                         valid;
  logic                         ready;
  fp_fmt_e                      fmt;
  logic [NumLanes-1:0]          lane_active;
  logic [NumLanes-1:0]          mask;
  logic [TAG_BITS-1:0]          tag;
  logic [Width-1:0]             result;      // Lane results in place at slot width
  status_t [NumLanes-1:0]       lane_status;

  modport producer (output valid, fmt, lane_active, mask, tag, result, lane_status,
                    input ready);
  modport consumer (input valid, fmt, lane_active, mask, tag, result, lane_status,
                    output ready);
endinterface

// File: src/lane_split.sv
// ------------------------------
// First pipeline stage, registers the request and works out active lanes
// Upstream handshake of the slice lives here
// ------------------------------
module lane_split import simd_fp_pkg::*; #(
  parameter  int unsigned Width    = 64,
  localparam int unsigned NumLanes = num_lanes(Width)
) (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                flush_i,
  input  logic [Width-1:0]    operands_a_i,
  input  logic [Width-1:0]    operands_b_i,
  input  noncomp_op_e         op_i,
  input  fp_fmt_e             fmt_i,
  input  logic                vectorial_op_i,
  input  logic [NumLanes-1:0] simd_mask_i,
  input  logic [TAG_BITS-1:0] tag_i,
  input  logic                in_valid_i,
  output logic                in_ready_o,
  lane_operand_if.producer    out_o
);

  logic [NumLanes-1:0] lane_active_d;
  logic                load;
  logic                valid_q;
  noncomp_op_e         op_q;
  fp_fmt_e             fmt_q;
  logic [NumLanes-1:0] active_q;
  logic [NumLanes-1:0] mask_q;
  logic [TAG_BITS-1:0] tag_q;
  logic [Width-1:0]    opa_q;
  logic [Width-1:0]    opb_q;

  // ------------------------------
  // Lane enable
  // ------------------------------
  // Lane 0 always runs, upper lanes only for vectors that fit the datapath
  always_comb begin : active_lanes
    for (int unsigned i = 0; i < NumLanes; i++) begin
      lane_active_d[i] = (i == 0) ||
                         (vectorial_op_i && ((i + 1) * fp_width(fmt_i) <= Width));
    end
  end

  // ------------------------------
  // Stage register
  // ------------------------------
  assign in_ready_o = ~valid_q | out_o.ready; // Empty or draining
  assign load       = in_valid_i & in_ready_o;

  always_ff @(posedge clk_i) begin : valid_reg
    if (reset_i || flush_i) begin
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      valid_q <= in_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin : payload_reg
    if (load) begin
      op_q     <= op_i;
      fmt_q    <= fmt_i;
      active_q <= lane_active_d;
      mask_q   <= simd_mask_i;
      tag_q    <= tag_i;
      opa_q    <= operands_a_i;
      opb_q    <= operands_b_i;
    end
  end

  assign out_o.valid       = valid_q;
  assign out_o.op          = op_q;
  assign out_o.fmt         = fmt_q;
  assign out_o.lane_active = active_q;
  assign out_o.mask        = mask_q;
  assign out_o.tag         = tag_q;
  assign out_o.opa         = opa_q;
  assign out_o.opb         = opb_q;

endmodule

// File: src/noncomp_lane.sv
// ------------------------------
// One lane of sign injection and min/max, purely combinational
// FP16 results sit in the low half with ones above
// ------------------------------
module noncomp_lane import simd_fp_pkg::*; (
  input  noncomp_op_e op_i,
  input  fp_fmt_e     fmt_i,
  input  logic [31:0] opa_i,
  input  logic [31:0] opb_i,
  output logic [31:0] result_o,
  output status_t     status_o
);

  logic        sign_a, sign_b, sign_r;
  logic [30:0] mag_a, mag_b;
  logic        nan_a, nan_b, snan_a, snan_b;
  logic        a_lt_b;
  logic        is_minmax;
  logic [31:0] canon_nan;
  logic [31:0] sgnj_val;
  logic [31:0] minmax_val;
  logic [31:0] value_r;

  // ------------------------------
  // Field access per format
  // ------------------------------
  function automatic logic sign_of(logic [31:0] x, fp_fmt_e f);
    return (f == FP16) ? x[15] : x[31];
  endfunction

  function automatic logic [30:0] magnitude(logic [31:0] x, fp_fmt_e f);
    return (f == FP16) ? {16'h0000, x[14:0]} : x[30:0];
  endfunction

  // All-ones exponent with a nonzero mantissa
  function automatic logic is_nan(logic [31:0] x, fp_fmt_e f);
    return (f == FP16) ? ((&x[14:10]) && (|x[9:0])) : ((&x[30:23]) && (|x[22:0]));
  endfunction

  function automatic logic quiet_bit(logic [31:0] x, fp_fmt_e f);
    return (f == FP16) ? x[9] : x[22];
  endfunction

  assign sign_a    = sign_of(opa_i, fmt_i);
  assign sign_b    = sign_of(opb_i, fmt_i);
  assign mag_a     = magnitude(opa_i, fmt_i);
  assign mag_b     = magnitude(opb_i, fmt_i);
  assign nan_a     = is_nan(opa_i, fmt_i);
  assign nan_b     = is_nan(opb_i, fmt_i);
  assign snan_a    = nan_a & ~quiet_bit(opa_i, fmt_i);
  assign snan_b    = nan_b & ~quiet_bit(opb_i, fmt_i);
  assign canon_nan = (fmt_i == FP16) ? {16'h0000, CANON_NAN_FP16} : CANON_NAN_FP32;
  assign is_minmax = (op_i == MIN) || (op_i == MAX);

  // Sign-magnitude order, so -0 sorts below +0 on the sign check
  always_comb begin : order
    if (sign_a != sign_b) a_lt_b = sign_a;
    else if (sign_a)      a_lt_b = mag_a > mag_b;
    else                  a_lt_b = mag_a < mag_b;
  end

  always_comb begin : sign_inject
    case (op_i)
      SGNJN:   sign_r = ~sign_b;
      SGNJX:   sign_r = sign_a ^ sign_b;
      default: sign_r = sign_b;
    endcase
    sgnj_val = (fmt_i == FP16) ? {16'h0000, sign_r, opa_i[14:0]} : {sign_r, opa_i[30:0]};
  end

  // A single NaN input yields the other operand
  always_comb begin : min_max
    if (nan_a && nan_b)                minmax_val = canon_nan;
    else if (nan_a)                    minmax_val = opb_i;
    else if (nan_b)                    minmax_val = opa_i;
    else if (a_lt_b == (op_i == MIN))  minmax_val = opa_i;
    else                               minmax_val = opb_i;
  end

  assign value_r  = is_minmax ? minmax_val : sgnj_val;
  assign result_o = (fmt_i == FP16) ? {16'hFFFF, value_r[15:0]} : value_r;

  always_comb begin : flags
    status_o    = '0;
    status_o.nv = is_minmax & (snan_a | snan_b); // Sign injection never signals
  end

endmodule

// File: src/lane_stage.sv
// ------------------------------
// Second pipeline stage, runs one noncomp unit per lane
// Results are registered in place at the format's slot width
// ------------------------------
module lane_stage import simd_fp_pkg::*; #(
  parameter  int unsigned Width    = 64,
  localparam int unsigned NumLanes = num_lanes(Width)
) (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             flush_i,
  lane_operand_if.consumer in_i,
  lane_result_if.producer  out_o
);

  logic [Width-1:0]       slot16, slot32;
  logic [Width-1:0]       result_d;
  status_t [NumLanes-1:0] status_d;
  logic                   load;
  logic                   valid_q;
  logic [Width-1:0]       result_q;
  status_t [NumLanes-1:0] status_q;
  fp_fmt_e                fmt_q;
  logic [NumLanes-1:0]    active_q;
  logic [NumLanes-1:0]    mask_q;
  logic [TAG_BITS-1:0]    tag_q;

  for (genvar i = 0; i < NumLanes; i++) begin : gen_lanes
    logic [31:0] opa_lane, opb_lane, res_lane;
    status_t     status_lane;

    assign opa_lane = 32'(in_i.opa >> (i * fp_width(in_i.fmt)));
    assign opb_lane = 32'(in_i.opb >> (i * fp_width(in_i.fmt)));

    noncomp_lane u_lane (
      .op_i     (in_i.op),
      .fmt_i    (in_i.fmt),
      .opa_i    (opa_lane),
      .opb_i    (opb_lane),
      .result_o (res_lane),
      .status_o (status_lane)
    );

    assign slot16[i*16 +: 16] = res_lane[15:0];
    if ((i + 1) * 32 <= Width) begin : gen_fp32_slot // Only lanes that hold a full FP32
      assign slot32[i*32 +: 32] = res_lane;
    end
    assign status_d[i] = in_i.lane_active[i] ? status_lane : '0;
  end

  assign result_d = (in_i.fmt == FP16) ? slot16 : slot32;

  // ------------------------------
  // Stage register
  // ------------------------------
  assign in_i.ready = ~valid_q | out_o.ready;
  assign load       = in_i.valid & in_i.ready;

  always_ff @(posedge clk_i) begin : valid_reg
    if (reset_i || flush_i) valid_q <= 1'b0;
    else if (in_i.ready)    valid_q <= in_i.valid;
  end

  always_ff @(posedge clk_i) begin : payload_reg
    if (load) begin
      result_q <= result_d;
      status_q <= status_d;
      fmt_q    <= in_i.fmt;
      active_q <= in_i.lane_active;
      mask_q   <= in_i.mask;
      tag_q    <= in_i.tag;
    end
  end

  assign out_o.valid       = valid_q;
  assign out_o.result      = result_q;
  assign out_o.lane_status = status_q;
  assign out_o.fmt         = fmt_q;
  assign out_o.lane_active = active_q;
  assign out_o.mask        = mask_q;
  assign out_o.tag         = tag_q;

endmodule

// File: src/result_pack.sv
// ------------------------------
// Last pipeline stage, NaN-boxes idle lanes and collapses the flags
// Output register holds until the consumer takes it
// ------------------------------
module result_pack import simd_fp_pkg::*; #(
  parameter  int unsigned Width    = 64,
  localparam int unsigned NumLanes = num_lanes(Width)
) (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                flush_i,
  input  logic                out_ready_i,
  lane_result_if.consumer     in_i,
  output logic [Width-1:0]    result_o,
  output status_t             status_o,
  output logic [TAG_BITS-1:0] tag_o,
  output logic                out_valid_o
);

  logic [Width-1:0]    boxed;
  status_t             status_d;
  logic                load;
  logic                out_valid_q;
  logic [Width-1:0]    result_q;
  status_t             status_q;
  logic [TAG_BITS-1:0] tag_q;

  // ------------------------------
  // Packing
  // ------------------------------
  // Bits of idle lanes or past the last lane read as ones
  always_comb begin : nan_box
    int unsigned lane_idx;
    for (int unsigned b = 0; b < Width; b++) begin
      lane_idx = b / fp_width(in_i.fmt);
      if ((lane_idx < NumLanes) && in_i.lane_active[lane_idx]) begin
        boxed[b] = in_i.result[b];
      end else begin
        boxed[b] = 1'b1;
      end
    end
  end

  // Flags of active lanes with their mask bit set
  always_comb begin : status_collapse
    status_d = '0;
    for (int unsigned i = 0; i < NumLanes; i++) begin
      if (in_i.lane_active[i] && in_i.mask[i]) begin
        status_d = status_d | in_i.lane_status[i];
      end
    end
  end

  // ------------------------------
  // Output register
  // ------------------------------
  assign in_i.ready = ~out_valid_q | out_ready_i;
  assign load       = in_i.valid & in_i.ready;

  always_ff @(posedge clk_i) begin : valid_reg
    if (reset_i || flush_i) begin
      out_valid_q <= 1'b0;
    end else if (in_i.ready) begin
      out_valid_q <= in_i.valid;
    end
  end

  always_ff @(posedge clk_i) begin : payload_reg
    if (load) begin
      result_q <= boxed;
      status_q <= status_d;
      tag_q    <= in_i.tag;
    end
  end

  assign result_o    = result_q;
  assign status_o    = status_q;
  assign tag_o       = tag_q;
  assign out_valid_o = out_valid_q;

endmodule

// File: src/simd_noncomp_slice.sv
// ------------------------------
// Three-stage SIMD sign-injection and min/max slice
// Split, compute and pack stages joined by valid/ready buses
// ------------------------------
module simd_noncomp_slice import simd_fp_pkg::*; #(
  parameter  int unsigned Width    = 64,
  localparam int unsigned NumLanes = num_lanes(Width)
) (
  input  logic                clk_i,
  input  logic                reset_i,
  // Request side
  input  logic [Width-1:0]    operands_a_i,
  input  logic [Width-1:0]    operands_b_i,
  input  noncomp_op_e         op_i,
  input  fp_fmt_e             fmt_i,
  input  logic                vectorial_op_i,
  input  logic [NumLanes-1:0] simd_mask_i,
  input  logic [TAG_BITS-1:0] tag_i,
  input  logic                in_valid_i,
  output logic                in_ready_o,
  input  logic                flush_i,
  // Response side
  output logic [Width-1:0]    result_o,
  output status_t             status_o,
  output logic [TAG_BITS-1:0] tag_o,
  output logic                out_valid_o,
  input  logic                out_ready_i,
  output logic                busy_o
);

  lane_operand_if #(.Width(Width)) op_if ();
  lane_result_if  #(.Width(Width)) res_if ();

  lane_split #(.Width(Width)) u_split (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .flush_i        (flush_i),
    .operands_a_i   (operands_a_i),
    .operands_b_i   (operands_b_i),
    .op_i           (op_i),
    .fmt_i          (fmt_i),
    .vectorial_op_i (vectorial_op_i),
    .simd_mask_i    (simd_mask_i),
    .tag_i          (tag_i),
    .in_valid_i     (in_valid_i),
    .in_ready_o     (in_ready_o),
    .out_o          (op_if.producer)
  );

  lane_stage #(.Width(Width)) u_lanes (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .flush_i (flush_i),
    .in_i    (op_if.consumer),
    .out_o   (res_if.producer)
  );

  result_pack #(.Width(Width)) u_pack (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .flush_i     (flush_i),
    .out_ready_i (out_ready_i),
    .in_i        (res_if.consumer),
    .result_o    (result_o),
    .status_o    (status_o),
    .tag_o       (tag_o),
    .out_valid_o (out_valid_o)
  );

  // Any stage holding an item
  assign busy_o = op_if.valid | res_if.valid | out_valid_o;

endmodule

// File: verification/slice_assert.sv
// ------------------------------
// Handshake and reset checks bound onto the slice top level
// ------------------------------
module slice_assert import simd_fp_pkg::*; #(
  parameter int unsigned Width = 64
) (
  input logic                clk_i,
  input logic                reset_i,
  input logic                out_valid_o,
  input logic                out_ready_i,
  input logic [Width-1:0]    result_o,
  input logic [TAG_BITS-1:0] tag_o,
  input logic                busy_o
);
  timeunit 1ns;
  timeprecision 1ps;

  // Output register comes out of reset empty
  reset_clears_output: assert property (@(posedge clk_i) reset_i |=> !out_valid_o)
    else $error("out_valid_o high after a reset cycle");

  // Stalled output keeps its payload
  stalled_output_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    (out_valid_o && !out_ready_i) |=> ($stable(result_o) && $stable(tag_o)))
    else $error("result_o or tag_o changed while stalled");

  // A valid output needs an item in flight one cycle earlier
  busy_covers_output: assert property (@(posedge clk_i) disable iff (reset_i)
    out_valid_o |-> $past(busy_o))
    else $error("out_valid_o high without busy_o on the cycle before");

endmodule

bind simd_noncomp_slice slice_assert #(.Width(Width)) u_slice_assert (
  .clk_i       (clk_i),
  .reset_i     (reset_i),
  .out_valid_o (out_valid_o),
  .out_ready_i (out_ready_i),
  .result_o    (result_o),
  .tag_o       (tag_o),
  .busy_o      (busy_o)
);

// File: verification/tb_simd_noncomp_slice.sv
// ------------------------------
// Self-checking testbench for the SIMD noncomp slice
// Reference model, queued expectations and an output compare process
// ------------------------------
module tb_simd_noncomp_slice import simd_fp_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned Width         = 64;
  localparam int unsigned NumLanes      = Width / 16;
  localparam int unsigned TimeoutCycles = 2000;

  typedef struct packed {
    logic [Width-1:0]    result;
    status_t             status;
    logic [TAG_BITS-1:0] tag;
  } expect_t;

  logic                clk_i, reset_i, flush_i;
  logic [Width-1:0]    operands_a_i, operands_b_i;
  noncomp_op_e         op_i;
  fp_fmt_e             fmt_i;
  logic                vectorial_op_i;
  logic [NumLanes-1:0] simd_mask_i;
  logic [TAG_BITS-1:0] tag_i;
  logic                in_valid_i, in_ready_o;
  logic [Width-1:0]    result_o;
  status_t             status_o;
  logic [TAG_BITS-1:0] tag_o;
  logic                out_valid_o, out_ready_i, busy_o;

  expect_t             exp_q[$];
  string               name_q[$];
  logic [TAG_BITS-1:0] next_tag;
  int unsigned         n_pushed, n_checked, n_flushed;
  logic                random_ready; // Random back-pressure on the output
  logic                ready_level;  // Output ready when not random

  simd_noncomp_slice #(.Width(Width)) uut (.*);

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // ------------------------------
  // Reporting and compare tasks
  // ------------------------------
  task automatic abort_run(input string why);
    $display("TEST FAIL");
    $fatal(1, "%s", why);
  endtask

  task automatic check_result(input string name, input logic [Width-1:0] expected,
                              input logic [Width-1:0] actual);
    if (actual !== expected) begin
      $display("** Error %s: result expected %h, actual %h", name, expected, actual);
      abort_run("result mismatch");
    end
  endtask

  task automatic check_status(input string name, input status_t expected, input status_t actual);
    if (actual !== expected) begin
      $display("** Error %s: status expected %b, actual %b", name, expected, actual);
      abort_run("status mismatch");
    end
  endtask

  task automatic check_tag(input string name, input logic [TAG_BITS-1:0] expected,
                           input logic [TAG_BITS-1:0] actual);
    if (actual !== expected) begin
      $display("** Error %s: tag expected %h, actual %h", name, expected, actual);
      abort_run("tag mismatch");
    end
  endtask

  // ------------------------------
  // Reference model
  // ------------------------------
  // One lane, value right-aligned; NaN is a magnitude above infinity
  function automatic logic [31:0] lane_ref(noncomp_op_e op, fp_fmt_e fmt, logic [31:0] a,
                                           logic [31:0] b, output logic nv);
    logic [31:0] top, ones, inf, qbit, x, y, ka, kb, res;
    logic        na, nb;
    top  = (fmt == FP16) ? 32'h0000_8000 : 32'h8000_0000;
    ones = (fmt == FP16) ? 32'h0000_FFFF : 32'hFFFF_FFFF;
    inf  = (fmt == FP16) ? 32'h0000_7C00 : 32'h7F80_0000;
    qbit = (fmt == FP16) ? 32'h0000_0200 : 32'h0040_0000;
    x    = a & ones;
    y    = b & ones;
    na   = (x & ~top) > inf;
    nb   = (y & ~top) > inf;
    ka   = (x & top) != 0 ? (~x & ones) : (x | top); // Monotonic keys, -0 below +0
    kb   = (y & top) != 0 ? (~y & ones) : (y | top);
    nv   = 1'b0;
    case (op)
      SGNJ:  res = (x & ~top) | (y & top);
      SGNJN: res = (x & ~top) | (~y & top);
      SGNJX: res = x ^ (y & top);
      default: begin
        nv = (na && (x & qbit) == 0) || (nb && (y & qbit) == 0);
        if (na && nb)     res = (fmt == FP16) ? 32'h0000_7E00 : 32'h7FC0_0000;
        else if (na)      res = y;
        else if (nb)      res = x;
        else if (op == MIN) res = (ka < kb) ? x : y;
        else              res = (ka > kb) ? x : y;
      end
    endcase
    return res;
  endfunction

  function automatic expect_t slice_model(logic [Width-1:0] a, logic [Width-1:0] b,
                                          noncomp_op_e op, fp_fmt_e fmt, logic vec,
                                          logic [NumLanes-1:0] mask, logic [TAG_BITS-1:0] tag);
    expect_t     e;
    logic [31:0] lr;
    logic        nv;
    int unsigned w;
    w        = (fmt == FP16) ? 16 : 32;
    e.result = '1; // Idle lanes stay NaN-boxed
    e.status = '0;
    e.tag    = tag;
    for (int unsigned i = 0; i < Width / w; i++) begin
      if (i == 0 || vec) begin
        lr = lane_ref(op, fmt, 32'(a >> (i * w)), 32'(b >> (i * w)), nv);
        if (fmt == FP16) e.result[i*16 +: 16] = lr[15:0];
        else             e.result[i*32 +: 32] = lr;
        if (mask[i]) e.status.nv = e.status.nv | nv;
      end
    end
    return e;
  endfunction

  // ------------------------------
  // Stimulus helpers
  // ------------------------------
  // Random lanes with some forced to NaN/inf or to signed zero
  function automatic logic [Width-1:0] rand_operand(fp_fmt_e fmt);
    logic [Width-1:0] v;
    int unsigned      w;
    v = {$urandom, $urandom};
    w = (fmt == FP16) ? 16 : 32;
    for (int unsigned i = 0; i < Width / w; i++) begin
      case ($urandom_range(0, 7))
        0:       v = v | (((fmt == FP16) ? 64'h7C00 : 64'h7F80_0000) << (i * w));
        1:       v = v & ~(((fmt == FP16) ? 64'h7FFF : 64'h7FFF_FFFF) << (i * w));
        default: v = v;
      endcase
    end
    return v;
  endfunction

  task automatic send_op(input string name, input logic [Width-1:0] a, input logic [Width-1:0] b,
                         input noncomp_op_e op, input fp_fmt_e fmt, input logic vec,
                         input logic [NumLanes-1:0] mask);
    int unsigned waited;
    logic        accepted;
    @(negedge clk_i);
    operands_a_i   = a;
    operands_b_i   = b;
    op_i           = op;
    fmt_i          = fmt;
    vectorial_op_i = vec;
    simd_mask_i    = mask;
    tag_i          = next_tag;
    in_valid_i     = 1'b1;
    accepted       = 1'b0;
    waited         = 0;
    while (!accepted) begin
      @(posedge clk_i);
      if (in_ready_o) begin
        accepted = 1'b1;
        exp_q.push_back(slice_model(a, b, op, fmt, vec, mask, next_tag));
        name_q.push_back(name);
        n_pushed++;
      end else if (waited > TimeoutCycles) begin
        abort_run("input was never accepted by the slice");
      end else begin
        waited++;
      end
    end
    next_tag++;
  endtask

  task automatic send_random(input string name, input int unsigned op_lo,
                             input int unsigned op_hi, input logic vec);
    fp_fmt_e fmt;
    fmt = fp_fmt_e'(1'($urandom_range(0, 1)));
    send_op(name, rand_operand(fmt), rand_operand(fmt),
            noncomp_op_e'(3'($urandom_range(op_lo, op_hi))), fmt, vec, NumLanes'($urandom));
  endtask

  task automatic set_ready(input logic rnd, input logic level);
    @(posedge clk_i);
    random_ready = rnd;
    ready_level  = level;
  endtask

  // Waits until every queued result came out and the pipeline is empty
  task automatic drain(input string phase);
    int unsigned waited;
    @(negedge clk_i);
    in_valid_i = 1'b0;
    waited     = 0;
    while (exp_q.size() != 0 || busy_o) begin
      @(negedge clk_i);
      if (waited > TimeoutCycles) abort_run({"pipeline did not drain during ", phase});
      waited++;
    end
  endtask

  // ------------------------------
  // Output side
  // ------------------------------
  initial begin : ready_drive
    out_ready_i = 1'b1;
    forever begin
      @(negedge clk_i);
      if (random_ready) out_ready_i = 1'($urandom_range(0, 1));
      else              out_ready_i = ready_level;
    end
  end

  initial begin : compare
    expect_t e;
    string   name;
    forever begin
      @(posedge clk_i);
      if (!reset_i && out_valid_o && out_ready_i) begin
        if (exp_q.size() == 0) begin
          abort_run("an output appeared with no operation pending");
        end else begin
          e    = exp_q.pop_front();
          name = name_q.pop_front();
          check_result(name, e.result, result_o);
          check_status(name, e.status, status_o);
          check_tag(name, e.tag, tag_o);
          n_checked++;
        end
      end
    end
  end

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial begin : stimulus
    void'($urandom(32'h1916));
    reset_i        = 1'b1;
    flush_i        = 1'b0;
    operands_a_i   = '0;
    operands_b_i   = '0;
    op_i           = SGNJ;
    fmt_i          = FP32;
    vectorial_op_i = 1'b0;
    simd_mask_i    = '0;
    tag_i          = '0;
    in_valid_i     = 1'b0;
    next_tag       = '0;
    n_pushed       = 0;
    n_checked      = 0;
    n_flushed      = 0;
    random_ready   = 1'b0;
    ready_level    = 1'b1;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    if (out_valid_o !== 1'b0 || busy_o !== 1'b0 || in_ready_o !== 1'b1) begin
      abort_run("handshake outputs are wrong after reset");
    end

    for (int i = 0; i < 60; i++) send_random("scalar_sgnj", SGNJ, SGNJX, 1'b0);
    drain("scalar sign injection");

    // qNaN, sNaN, signed zeros and a plain pair per lane
    send_op("vec_minmax_fp16", 64'h7E00_7C01_8000_3C00, 64'h7FFF_3C00_0000_FC01, MIN, FP16,
            1'b1, 4'b1111);
    send_op("vec_minmax_fp16", 64'h7E00_7C01_8000_3C00, 64'h7FFF_3C00_0000_FC01, MAX, FP16,
            1'b1, 4'b1111);
    send_op("vec_minmax_fp32", 64'h7F80_0001_8000_0000, 64'h7FC0_0000_0000_0000, MIN, FP32,
            1'b1, 4'b1111);
    send_op("vec_minmax_fp32", 64'hFFC0_0000_0000_0000, 64'h7FC0_0001_8000_0000, MAX, FP32,
            1'b1, 4'b1111);
    for (int i = 0; i < 100; i++) send_random("vec_minmax_rand", MIN, MAX, 1'b1);
    drain("vectorial min/max");

    // sNaN in lane 2, masked off and then unmasked
    send_op("mask_gating", 64'h3C00_7C01_3C00_3C00, 64'h4000_4000_4000_4000, MIN, FP16,
            1'b1, 4'b1011);
    send_op("mask_gating", 64'h3C00_7C01_3C00_3C00, 64'h4000_4000_4000_4000, MIN, FP16,
            1'b1, 4'b1111);
    drain("mask gating");

    set_ready(1'b1, 1'b1);
    for (int i = 0; i < 500; i++) send_random("back_pressure", SGNJ, MAX, 1'($urandom));
    drain("back-pressure");
    set_ready(1'b0, 1'b0);

    // Fill all three stages with the output stalled, then flush
    for (int i = 0; i < 3; i++) send_random("flush_victim", SGNJ, MAX, 1'b1);
    @(negedge clk_i);
    in_valid_i = 1'b0;
    if (busy_o !== 1'b1) abort_run("busy_o low with items in flight");
    flush_i   = 1'b1;
    n_flushed = n_flushed + exp_q.size();
    exp_q.delete();
    name_q.delete();
    @(negedge clk_i);
    flush_i = 1'b0;
    if (out_valid_o !== 1'b0 || busy_o !== 1'b0) abort_run("pipeline not empty after flush");
    set_ready(1'b0, 1'b1);
    repeat (5) @(negedge clk_i); // Any output here has no queue entry and fails
    for (int i = 0; i < 20; i++) send_random("after_flush", SGNJ, MAX, 1'($urandom));
    drain("post-flush operations");

    if (exp_q.size() == 0 && n_checked + n_flushed == n_pushed) begin
      $display("TEST PASS");
      $finish;
    end else begin
      abort_run("result count does not match the accepted operations");
    end
  end

endmodule

// File: src.f
src/simd_fp_pkg.sv
src/lane_if.sv
src/lane_split.sv
src/noncomp_lane.sv
src/lane_stage.sv
src/result_pack.sv
src/simd_noncomp_slice.sv
verification/slice_assert.sv
verification/tb_simd_noncomp_slice.sv

// File: Makefile
# Verilator build and run of the SIMD noncomp slice testbench
TOP   := tb_simd_noncomp_slice
BUILD := obj_dir

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f src.f --top-module $(TOP) --Mdir $(BUILD) -o V$(TOP)

run: build
	./$(BUILD)/V$(TOP)

lint:
	verilator --lint-only -Wall --timing --assert --timescale 1ns/1ps \
		-f src.f --top-module $(TOP)

clean:
	rm -rf $(BUILD)
